// File: logic/router_pkg.sv
package router_pkg;

    //////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////

    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 16;
    localparam int WBEN_W    = 4;
    localparam int RAM_IDX_W = 12;
    localparam int REG_IDX_W = 3;

    // Target selected by address bits 15:14
    // Code 11 also lands on the register bank, the decoder folds it to REG
    typedef enum logic [1:0] {
        REGION_INST = 2'b00,
        REGION_DATA = 2'b01,
        REGION_REG  = 2'b10
    } region_t;

    // Transfer size as the core drives it, anything else counts as a word
    typedef enum logic [2:0] {
        SIZE_BYTE = 3'b000,
        SIZE_HALF = 3'b001,
        SIZE_WORD = 3'b010
    } size_t;

    //////////////////////////////////////////////////
    // Address word, memory view and register view
    //////////////////////////////////////////////////

    typedef union packed {
        struct packed {
            region_t                     region;
            logic [RAM_IDX_W-1:0]        index;
            logic [1:0]                  offset;
        } mem;
        struct packed {
            region_t                     region;
            logic [ADDR_W-REG_IDX_W-5:0] unused;
            logic [REG_IDX_W-1:0]        index;
            logic [1:0]                  offset;
        } regs;
    } bus_addr_u;

endpackage

// File: logic/router_decode.sv
`timescale 1ns/1ps

module router_decode import router_pkg::*; (
    input  bus_addr_u            addr,
    input  size_t                size,
    output region_t              region,
    output logic [RAM_IDX_W-1:0] index,
    output logic [WBEN_W-1:0]    wben
);

    logic [1:0] offset;

    // Both codes with the top bit set go to the register bank
    assign region = addr.mem.region[1] ? REGION_REG : addr.mem.region;

    // Byte offset sits in bits 1:0 in both views
    assign offset = addr.mem.offset;

    //////////////////////////////////////////////////
    // Index in the matching view
    //////////////////////////////////////////////////

    always_comb begin
        if (region == REGION_REG) begin
            // Register index sits in bits 4:2
            index = RAM_IDX_W'(addr.regs.index);
        end else begin
            index = addr.mem.index;
        end
    end

    //////////////////////////////////////////////////
    // Byte lane enables
    //////////////////////////////////////////////////

    always_comb begin
        case (size)
            SIZE_BYTE: begin
                case (offset)
                    2'b00:   wben = 4'b0001;
                    2'b01:   wben = 4'b0010;
                    2'b10:   wben = 4'b0100;
                    default: wben = 4'b1000;
                endcase
            end
            SIZE_HALF: begin
                // Halfword uses bit 1 only, bit 0 is ignored
                if (offset[1]) begin
                    wben = 4'b1100;
                end else begin
                    wben = 4'b0011;
                end
            end
            default: begin
                // Word and any unknown size
                wben = 4'b1111;
            end
        endcase
    end

endmodule

// File: logic/router_arbiter.sv
`timescale 1ns/1ps

module router_arbiter import router_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,

    // Decoded master requests
    input  logic                 imem_valid,
    input  logic                 dmem_valid,
    input  logic                 imem_write,
    input  logic                 dmem_write,
    input  region_t              imem_region,
    input  region_t              dmem_region,
    input  logic [RAM_IDX_W-1:0] imem_index,
    input  logic [RAM_IDX_W-1:0] dmem_index,
    input  logic [WBEN_W-1:0]    imem_wben,
    input  logic [WBEN_W-1:0]    dmem_wben,
    input  logic [DATA_W-1:0]    imem_wdata,
    input  logic [DATA_W-1:0]    dmem_wdata,
    input  logic                 imem_done,
    input  logic                 dmem_done,

    // Instruction RAM
    output logic                 inst_valid,
    output logic                 inst_rwn,
    output logic [RAM_IDX_W-1:0] inst_addr,
    output logic [DATA_W-1:0]    inst_wdata,
    output logic [WBEN_W-1:0]    inst_wben,

    // Data RAM
    output logic                 data_valid,
    output logic                 data_rwn,
    output logic [RAM_IDX_W-1:0] data_addr,
    output logic [DATA_W-1:0]    data_wdata,
    output logic [WBEN_W-1:0]    data_wben,

    // Peripheral registers
    output logic                 reg_valid,
    output logic                 reg_rwn,
    output logic [REG_IDX_W-1:0] reg_addr,
    output logic [DATA_W-1:0]    reg_wdata,
    output logic [WBEN_W-1:0]    reg_wben,

    // To the response stage
    output logic                 imem_issue,
    output logic                 dmem_issue,
    output region_t              imem_issued_region,
    output region_t              dmem_issued_region
);

    // Target bit order: 0 instruction RAM, 1 data RAM, 2 registers
    logic       imem_busy;
    logic       dmem_busy;
    logic       imem_req;
    logic       dmem_req;
    logic [2:0] imem_want;
    logic [2:0] dmem_want;
    logic [2:0] conflict;
    logic [2:0] imem_win;
    logic [2:0] dmem_win;
    logic [2:0] favour_dmem;

    //////////////////////////////////////////////////
    // Per target round robin
    //////////////////////////////////////////////////

    // A master in flight is not looked at again until its ready
    assign imem_req = imem_valid & ~imem_busy;
    assign dmem_req = dmem_valid & ~dmem_busy;

    assign imem_want[0] = imem_req & (imem_region == REGION_INST);
    assign imem_want[1] = imem_req & (imem_region == REGION_DATA);
    assign imem_want[2] = imem_req & imem_region[1];

    assign dmem_want[0] = dmem_req & (dmem_region == REGION_INST);
    assign dmem_want[1] = dmem_req & (dmem_region == REGION_DATA);
    assign dmem_want[2] = dmem_req & dmem_region[1];

    // At most one bit can be set, each master asks for one target
    assign conflict = imem_want & dmem_want;
    assign imem_win = imem_want & ~(conflict & favour_dmem);
    assign dmem_win = dmem_want & ~(conflict & ~favour_dmem);

    always_ff @(posedge clk) begin
        if (reset) begin
            // Instruction RAM favours imem, data RAM and registers favour dmem
            favour_dmem <= 3'b110;
            imem_busy   <= 1'b0;
            dmem_busy   <= 1'b0;
            imem_issue  <= 1'b0;
            dmem_issue  <= 1'b0;
        end else begin
            favour_dmem <= favour_dmem ^ conflict;
            imem_issue  <= |imem_win;
            dmem_issue  <= |dmem_win;

            if (|imem_win) begin
                imem_busy <= 1'b1;
            end else if (imem_done) begin
                imem_busy <= 1'b0;
            end

            if (|dmem_win) begin
                dmem_busy <= 1'b1;
            end else if (dmem_done) begin
                dmem_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|imem_win) begin
            imem_issued_region <= imem_region;
        end
        if (|dmem_win) begin
            dmem_issued_region <= dmem_region;
        end
    end

    //////////////////////////////////////////////////
    // Target command registers
    //////////////////////////////////////////////////

    // Valid only in the cycle after an issue
    always_ff @(posedge clk) begin
        if (reset) begin
            inst_valid <= 1'b0;
            data_valid <= 1'b0;
            reg_valid  <= 1'b0;
        end else begin
            inst_valid <= imem_win[0] | dmem_win[0];
            data_valid <= imem_win[1] | dmem_win[1];
            reg_valid  <= imem_win[2] | dmem_win[2];
        end
    end

    // Command held from the last issue
    always_ff @(posedge clk) begin
        if (imem_win[0] | dmem_win[0]) begin
            inst_rwn   <= dmem_win[0] ? ~dmem_write : ~imem_write;
            inst_addr  <= dmem_win[0] ? dmem_index  : imem_index;
            inst_wdata <= dmem_win[0] ? dmem_wdata  : imem_wdata;
            inst_wben  <= dmem_win[0] ? dmem_wben   : imem_wben;
        end

        if (imem_win[1] | dmem_win[1]) begin
            data_rwn   <= dmem_win[1] ? ~dmem_write : ~imem_write;
            data_addr  <= dmem_win[1] ? dmem_index  : imem_index;
            data_wdata <= dmem_win[1] ? dmem_wdata  : imem_wdata;
            data_wben  <= dmem_win[1] ? dmem_wben   : imem_wben;
        end

        // Register bank takes only the low index bits
        if (imem_win[2] | dmem_win[2]) begin
            reg_rwn   <= dmem_win[2] ? ~dmem_write : ~imem_write;
            reg_addr  <= dmem_win[2] ? dmem_index[REG_IDX_W-1:0]
                                     : imem_index[REG_IDX_W-1:0];
            reg_wdata <= dmem_win[2] ? dmem_wdata  : imem_wdata;
            reg_wben  <= dmem_win[2] ? dmem_wben   : imem_wben;
        end
    end

endmodule

// File: logic/router_response.sv
`timescale 1ns/1ps

module router_response import router_pkg::*; (
    input  logic              clk,
    input  logic              reset,

    // Issue strobes from the arbiter
    input  logic              imem_issue,
    input  logic              dmem_issue,
    input  region_t           imem_issued_region,
    input  region_t           dmem_issued_region,

    // Combinational read data from the targets
    input  logic [DATA_W-1:0] inst_rdata,
    input  logic [DATA_W-1:0] data_rdata,
    input  logic [DATA_W-1:0] reg_rdata,

    // Back to the masters
    output logic              imem_ready,
    output logic              dmem_ready,
    output logic [DATA_W-1:0] imem_rdata,
    output logic [DATA_W-1:0] dmem_rdata
);

    logic [DATA_W-1:0] imem_sel_rdata;
    logic [DATA_W-1:0] dmem_sel_rdata;

    // Read data of the target a master was issued to
    function automatic logic [DATA_W-1:0] pick_rdata(
        input region_t           region,
        input logic [DATA_W-1:0] inst,
        input logic [DATA_W-1:0] data,
        input logic [DATA_W-1:0] regs
    );
        logic [DATA_W-1:0] result;
        if (region[1]) begin
            result = regs;
        end else if (region == REGION_DATA) begin
            result = data;
        end else begin
            result = inst;
        end
        return result;
    endfunction

    assign imem_sel_rdata = pick_rdata(imem_issued_region, inst_rdata, data_rdata, reg_rdata);
    assign dmem_sel_rdata = pick_rdata(dmem_issued_region, inst_rdata, data_rdata, reg_rdata);

    //////////////////////////////////////////////////
    // Ready pulse one cycle after the issue
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            imem_ready <= 1'b0;
            dmem_ready <= 1'b0;
        end else begin
            imem_ready <= imem_issue;
            dmem_ready <= dmem_issue;
        end
    end

    // Writes capture too, the master ignores it
    always_ff @(posedge clk) begin
        if (imem_issue) begin
            imem_rdata <= imem_sel_rdata;
        end
        if (dmem_issue) begin
            dmem_rdata <= dmem_sel_rdata;
        end
    end

endmodule

// File: logic/bus_router.sv
`timescale 1ns/1ps

module bus_router import router_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,

    // Instruction fetch master
    input  logic                 imem_valid,
    input  logic [ADDR_W-1:0]    imem_addr,
    input  logic                 imem_write,
    input  size_t                imem_size,
    input  logic [DATA_W-1:0]    imem_wdata,
    output logic                 imem_ready,
    output logic [DATA_W-1:0]    imem_rdata,

    // Load/store master
    input  logic                 dmem_valid,
    input  logic [ADDR_W-1:0]    dmem_addr,
    input  logic                 dmem_write,
    input  size_t                dmem_size,
    input  logic [DATA_W-1:0]    dmem_wdata,
    output logic                 dmem_ready,
    output logic [DATA_W-1:0]    dmem_rdata,

    // Instruction RAM
    output logic                 inst_valid,
    output logic                 inst_rwn,
    output logic [RAM_IDX_W-1:0] inst_addr,
    output logic [DATA_W-1:0]    inst_wdata,
    output logic [WBEN_W-1:0]    inst_wben,
    input  logic [DATA_W-1:0]    inst_rdata,

    // Data RAM
    output logic                 data_valid,
    output logic                 data_rwn,
    output logic [RAM_IDX_W-1:0] data_addr,
    output logic [DATA_W-1:0]    data_wdata,
    output logic [WBEN_W-1:0]    data_wben,
    input  logic [DATA_W-1:0]    data_rdata,

    // Peripheral registers
    output logic                 reg_valid,
    output logic                 reg_rwn,
    output logic [REG_IDX_W-1:0] reg_addr,
    output logic [DATA_W-1:0]    reg_wdata,
    output logic [WBEN_W-1:0]    reg_wben,
    input  logic [DATA_W-1:0]    reg_rdata
);

    region_t              imem_region;
    region_t              dmem_region;
    logic [RAM_IDX_W-1:0] imem_index;
    logic [RAM_IDX_W-1:0] dmem_index;
    logic [WBEN_W-1:0]    imem_wben;
    logic [WBEN_W-1:0]    dmem_wben;
    logic                 imem_issue;
    logic                 dmem_issue;
    region_t              imem_issued_region;
    region_t              dmem_issued_region;

    //////////////////////////////////////////////////
    // Address decode, one per master
    //////////////////////////////////////////////////

    router_decode u_imem_decode (
        .addr   (imem_addr),
        .size   (imem_size),
        .region (imem_region),
        .index  (imem_index),
        .wben   (imem_wben)
    );

    router_decode u_dmem_decode (
        .addr   (dmem_addr),
        .size   (dmem_size),
        .region (dmem_region),
        .index  (dmem_index),
        .wben   (dmem_wben)
    );

    //////////////////////////////////////////////////
    // Arbitration and response
    //////////////////////////////////////////////////

    router_arbiter u_arbiter (.*, .imem_done(imem_ready), .dmem_done(dmem_ready));

    router_response u_response (.*);

endmodule

// File: verification/bus_router_assert.sv
`timescale 1ns/1ps

module bus_router_assert import router_pkg::*; (
    input logic                 clk,
    input logic                 reset,
    input logic                 imem_valid,
    input logic [ADDR_W-1:0]    imem_addr,
    input logic                 imem_write,
    input size_t                imem_size,
    input logic                 imem_ready,
    input logic                 dmem_valid,
    input logic [ADDR_W-1:0]    dmem_addr,
    input logic                 dmem_write,
    input size_t                dmem_size,
    input logic                 dmem_ready,
    input logic                 inst_valid,
    input logic                 inst_rwn,
    input logic [RAM_IDX_W-1:0] inst_addr,
    input logic [WBEN_W-1:0]    inst_wben,
    input logic                 data_valid,
    input logic                 data_rwn,
    input logic [RAM_IDX_W-1:0] data_addr,
    input logic [WBEN_W-1:0]    data_wben,
    input logic                 reg_valid,
    input logic                 reg_rwn,
    input logic [REG_IDX_W-1:0] reg_addr,
    input logic [WBEN_W-1:0]    reg_wben,
    input logic                 imem_issue,
    input logic                 dmem_issue
);

    int         error_count;
    logic       imem_busy_m;
    logic       dmem_busy_m;
    logic [2:0] fav_dmem_m;
    logic       imem_free;
    logic       dmem_free;
    logic       clash;
    logic [1:0] clash_t;
    logic [1:0] check_t;
    logic       check_winner;
    logic       winner_dmem;
    logic [2:0] tgt_valid;
    logic [2:0] tgt_rwn;

    function automatic logic [1:0] target_of(input logic [ADDR_W-1:0] a);
        return a[15] ? 2'd2 : {1'b0, a[14]};
    endfunction

    // Lane rule for a held request
    function automatic logic [3:0] lanes(input size_t s, input logic [1:0] off);
        if (s == SIZE_BYTE) begin
            return 4'b0001 << off;
        end else if (s == SIZE_HALF) begin
            return off[1] ? 4'b1100 : 4'b0011;
        end
        return 4'b1111;
    endfunction

    function automatic logic [3:0] wben_of(input logic [1:0] t, input logic [3:0] iw,
                                           input logic [3:0] dw, input logic [3:0] rw);
        return (t == 2'd2) ? rw : (t == 2'd1) ? dw : iw;
    endfunction

    // True when the target of t carries the command of address a
    function automatic logic command_ok(input logic [1:0] t, input logic [ADDR_W-1:0] a,
                                        input logic write, input logic [2:0] valid,
                                        input logic [2:0] rwn,
                                        input logic [RAM_IDX_W-1:0] i_addr,
                                        input logic [RAM_IDX_W-1:0] d_addr,
                                        input logic [REG_IDX_W-1:0] r_addr);
        logic addr_ok;
        if (t == 2'd2) begin
            addr_ok = r_addr == a[4:2];
        end else if (t == 2'd1) begin
            addr_ok = d_addr == a[13:2];
        end else begin
            addr_ok = i_addr == a[13:2];
        end
        return valid[t] && rwn[t] == !write && addr_ok;
    endfunction

    assign tgt_valid = {reg_valid, data_valid, inst_valid};
    assign tgt_rwn   = {reg_rwn, data_rwn, inst_rwn};

    //////////////////////////////////////////////////
    // Expected round robin
    //////////////////////////////////////////////////

    assign imem_free = imem_valid && !imem_busy_m;
    assign dmem_free = dmem_valid && !dmem_busy_m;
    assign clash_t   = target_of(imem_addr);
    assign clash     = imem_free && dmem_free && clash_t == target_of(dmem_addr);

    always_ff @(posedge clk) begin
        if (reset) begin
            imem_busy_m  <= 1'b0;
            dmem_busy_m  <= 1'b0;
            fav_dmem_m   <= 3'b110;
            check_winner <= 1'b0;
            winner_dmem  <= 1'b0;
            check_t      <= 2'd0;
        end else begin
            check_winner <= clash;
            if (clash) begin
                winner_dmem         <= fav_dmem_m[clash_t];
                check_t             <= clash_t;
                fav_dmem_m[clash_t] <= ~fav_dmem_m[clash_t];
            end
            if (imem_free && !(clash && fav_dmem_m[clash_t])) begin
                imem_busy_m <= 1'b1;
            end else if (imem_ready) begin
                imem_busy_m <= 1'b0;
            end
            if (dmem_free && !(clash && !fav_dmem_m[clash_t])) begin
                dmem_busy_m <= 1'b1;
            end else if (dmem_ready) begin
                dmem_busy_m <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Protocol and data rules
    //////////////////////////////////////////////////

    idle_after_reset: assert property (@(posedge clk)
        reset |=> !(inst_valid || data_valid || reg_valid || imem_ready || dmem_ready))
        else begin error_count++; $error("target valid or ready high after reset"); end

    imem_ready_needs_valid: assert property (@(posedge clk) disable iff (reset)
        imem_ready |-> imem_valid)
        else begin error_count++; $error("imem ready without valid"); end

    dmem_ready_needs_valid: assert property (@(posedge clk) disable iff (reset)
        dmem_ready |-> dmem_valid)
        else begin error_count++; $error("dmem ready without valid"); end

    imem_ready_pulse: assert property (@(posedge clk) disable iff (reset)
        imem_ready |=> !imem_ready)
        else begin error_count++; $error("imem ready longer than one cycle"); end

    dmem_ready_pulse: assert property (@(posedge clk) disable iff (reset)
        dmem_ready |=> !dmem_ready)
        else begin error_count++; $error("dmem ready longer than one cycle"); end

    imem_latency: assert property (@(posedge clk) disable iff (reset)
        imem_valid |-> ##[0:6] imem_ready)
        else begin error_count++; $error("imem request got no ready in 6 cycles"); end

    dmem_latency: assert property (@(posedge clk) disable iff (reset)
        dmem_valid |-> ##[0:6] dmem_ready)
        else begin error_count++; $error("dmem request got no ready in 6 cycles"); end

    imem_wben_rule: assert property (@(posedge clk) disable iff (reset)
        imem_issue && imem_write |->
            wben_of(target_of(imem_addr), inst_wben, data_wben, reg_wben)
                == lanes(imem_size, imem_addr[1:0]))
        else begin error_count++; $error("imem write lanes wrong"); end

    dmem_wben_rule: assert property (@(posedge clk) disable iff (reset)
        dmem_issue && dmem_write |->
            wben_of(target_of(dmem_addr), inst_wben, data_wben, reg_wben)
                == lanes(dmem_size, dmem_addr[1:0]))
        else begin error_count++; $error("dmem write lanes wrong"); end

    imem_decode: assert property (@(posedge clk) disable iff (reset)
        imem_issue |-> command_ok(target_of(imem_addr), imem_addr, imem_write,
                                  tgt_valid, tgt_rwn, inst_addr, data_addr, reg_addr))
        else begin error_count++; $error("imem command on wrong target"); end

    dmem_decode: assert property (@(posedge clk) disable iff (reset)
        dmem_issue |-> command_ok(target_of(dmem_addr), dmem_addr, dmem_write,
                                  tgt_valid, tgt_rwn, inst_addr, data_addr, reg_addr))
        else begin error_count++; $error("dmem command on wrong target"); end

    // No target wakes up without an issue behind it
    only_issued_targets: assert property (@(posedge clk) disable iff (reset)
        $countones(tgt_valid) == $countones({imem_issue, dmem_issue}))
        else begin error_count++; $error("target valid count differs from issues"); end

    round_robin: assert property (@(posedge clk) disable iff (reset)
        check_winner |-> (winner_dmem
            ? (dmem_issue && !imem_issue
                && command_ok(check_t, dmem_addr, dmem_write,
                              tgt_valid, tgt_rwn, inst_addr, data_addr, reg_addr))
            : (imem_issue && !dmem_issue
                && command_ok(check_t, imem_addr, imem_write,
                              tgt_valid, tgt_rwn, inst_addr, data_addr, reg_addr))))
        else begin error_count++; $error("conflict granted to the wrong master"); end

endmodule

// File: verification/bus_router_tb.sv
`timescale 1ns/1ps

module bus_router_tb import router_pkg::*;;

    parameter int SEED = 92;

    logic                 clk;
    logic                 reset;
    logic                 imem_valid;
    logic [ADDR_W-1:0]    imem_addr;
    logic                 imem_write;
    size_t                imem_size;
    logic [DATA_W-1:0]    imem_wdata;
    logic                 imem_ready;
    logic [DATA_W-1:0]    imem_rdata;
    logic                 dmem_valid;
    logic [ADDR_W-1:0]    dmem_addr;
    logic                 dmem_write;
    size_t                dmem_size;
    logic [DATA_W-1:0]    dmem_wdata;
    logic                 dmem_ready;
    logic [DATA_W-1:0]    dmem_rdata;
    logic                 inst_valid;
    logic                 inst_rwn;
    logic [RAM_IDX_W-1:0] inst_addr;
    logic [DATA_W-1:0]    inst_wdata;
    logic [WBEN_W-1:0]    inst_wben;
    logic [DATA_W-1:0]    inst_rdata;
    logic                 data_valid;
    logic                 data_rwn;
    logic [RAM_IDX_W-1:0] data_addr;
    logic [DATA_W-1:0]    data_wdata;
    logic [WBEN_W-1:0]    data_wben;
    logic [DATA_W-1:0]    data_rdata;
    logic                 reg_valid;
    logic                 reg_rwn;
    logic [REG_IDX_W-1:0] reg_addr;
    logic [DATA_W-1:0]    reg_wdata;
    logic [WBEN_W-1:0]    reg_wben;
    logic [DATA_W-1:0]    reg_rdata;

    // Target storage driven by the router, and the testbench's own model
    logic [DATA_W-1:0] inst_mem [0:4095];
    logic [DATA_W-1:0] data_mem [0:4095];
    logic [DATA_W-1:0] reg_mem [0:7];
    logic [DATA_W-1:0] inst_model [0:4095];
    logic [DATA_W-1:0] data_model [0:4095];
    logic [DATA_W-1:0] reg_model [0:7];
    int seed;

    bus_router uut (.*);

    bind bus_router bus_router_assert u_assert (.*);

    always #20 clk = ~clk;

    //////////////////////////////////////////////////
    // Target models
    //////////////////////////////////////////////////

    assign inst_rdata = inst_mem[inst_addr];
    assign data_rdata = data_mem[data_addr];
    assign reg_rdata  = reg_mem[reg_addr];

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] wd,
                                          input logic [3:0] en);
        logic [31:0] result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (en[b]) begin
                result[8*b +: 8] = wd[8*b +: 8];
            end
        end
        return result;
    endfunction

    always @(posedge clk) begin
        if (inst_valid && !inst_rwn) begin
            inst_mem[inst_addr] <= merge(inst_mem[inst_addr], inst_wdata, inst_wben);
        end
        if (data_valid && !data_rwn) begin
            data_mem[data_addr] <= merge(data_mem[data_addr], data_wdata, data_wben);
        end
        if (reg_valid && !reg_rwn) begin
            reg_mem[reg_addr] <= merge(reg_mem[reg_addr], reg_wdata, reg_wben);
        end
    end

    // Assertion failures end the run at the next falling edge
    always @(negedge clk) begin
        if (uut.u_assert.error_count != 0) begin
            $display("SIMULATION FAILED");
            $fatal(1, "an assertion on the router failed");
        end
    end

    //////////////////////////////////////////////////
    // Expected contents
    //////////////////////////////////////////////////

    function automatic logic [31:0] fill(input logic [1:0] region, input int idx);
        return ({region, idx[13:0]} * 32'h9e37_79b1) ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] model_read(input logic [15:0] a);
        if (a[15]) begin
            return reg_model[a[4:2]];
        end else if (a[14]) begin
            return data_model[a[13:2]];
        end
        return inst_model[a[13:2]];
    endfunction

    function automatic void model_write(input logic [15:0] a, input size_t s,
                                        input logic [31:0] wd);
        logic [3:0]  en;
        logic [31:0] word;
        if (s == SIZE_BYTE) begin
            en = 4'b0001 << a[1:0];
        end else if (s == SIZE_HALF) begin
            en = a[1] ? 4'b1100 : 4'b0011;
        end else begin
            en = 4'b1111;
        end
        word = merge(model_read(a), wd, en);
        if (a[15]) begin
            reg_model[a[4:2]] = word;
        end else if (a[14]) begin
            data_model[a[13:2]] = word;
        end else begin
            inst_model[a[13:2]] = word;
        end
    endfunction

    //////////////////////////////////////////////////
    // Master requests
    //////////////////////////////////////////////////

    task automatic access(input logic dmem, input logic [15:0] a, input logic write,
                          input size_t s, input logic [31:0] wd, output logic [31:0] rd);
        int   waited;
        logic done;
        waited = 0;
        done = 1'b0;
        rd = '0;
        @(posedge clk);
        if (dmem) begin
            dmem_valid <= 1'b1;
            dmem_addr  <= a;
            dmem_write <= write;
            dmem_size  <= s;
            dmem_wdata <= wd;
        end else begin
            imem_valid <= 1'b1;
            imem_addr  <= a;
            imem_write <= write;
            imem_size  <= s;
            imem_wdata <= wd;
        end
        while (!done) begin
            @(posedge clk);
            waited++;
            if (dmem ? dmem_ready : imem_ready) begin
                done = 1'b1;
                rd = dmem ? dmem_rdata : imem_rdata;
                if (dmem) begin
                    dmem_valid <= 1'b0;
                end else begin
                    imem_valid <= 1'b0;
                end
            end else if (waited > 20) begin
                $display("request timed out: %s at address %h", dmem ? "dmem" : "imem", a);
                $display("SIMULATION FAILED");
                $fatal(1, "no ready from the router");
            end
        end
        if (write) begin
            model_write(a, s, wd);
        end
    endtask

    task automatic check_read(input logic dmem, input logic [15:0] a, input string name);
        logic [31:0] expected;
        logic [31:0] actual;
        access(dmem, a, 1'b0, SIZE_WORD, '0, actual);
        expected = model_read(a);
        if (actual !== expected) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "read data mismatch");
        end
    endtask

    // Every size and offset into one word, each followed by a readback
    task automatic lane_sweep(input logic dmem, input logic [15:0] word_addr,
                              input string name);
        logic [31:0] unused;
        for (int off = 0; off < 4; off++) begin
            access(dmem, word_addr | 16'(off), 1'b1, SIZE_BYTE, $random(seed), unused);
            check_read(dmem, word_addr, {name, " byte"});
        end
        for (int off = 0; off < 4; off += 2) begin
            access(dmem, word_addr | 16'(off), 1'b1, SIZE_HALF, $random(seed), unused);
            check_read(dmem, word_addr, {name, " half"});
        end
        access(dmem, word_addr, 1'b1, SIZE_WORD, $random(seed), unused);
        check_read(dmem, word_addr, {name, " word"});
    endtask

    // Both masters start on the same edge toward one region
    task automatic contend(input logic [1:0] region, input int rounds, input string name);
        logic [15:0] ia;
        logic [15:0] da;
        for (int r = 0; r < rounds; r++) begin
            ia = {region, 14'($random(seed)) & 14'h3ffc};
            da = ia ^ 16'h0004;
            fork
                check_read(1'b0, ia, {name, " imem"});
                check_read(1'b1, da, {name, " dmem"});
            join
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        logic [15:0] a;
        logic [31:0] unused;
        seed = SEED;
        clk = 1'b0;
        reset = 1'b1;
        imem_valid = 1'b0;
        imem_addr = '0;
        imem_write = 1'b0;
        imem_size = SIZE_WORD;
        imem_wdata = '0;
        dmem_valid = 1'b0;
        dmem_addr = '0;
        dmem_write = 1'b0;
        dmem_size = SIZE_WORD;
        dmem_wdata = '0;
        for (int i = 0; i < 4096; i++) begin
            inst_mem[i] = fill(2'd0, i);
            data_mem[i] = fill(2'd1, i);
            inst_model[i] = fill(2'd0, i);
            data_model[i] = fill(2'd1, i);
        end
        for (int i = 0; i < 8; i++) begin
            reg_mem[i] = fill(2'd2, i);
            reg_model[i] = fill(2'd2, i);
        end

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);

        // Byte lanes on every target from both masters
        lane_sweep(1'b0, 16'h0000 | (16'($random(seed)) & 16'h3ffc), "inst lanes");
        lane_sweep(1'b1, 16'h4000 | (16'($random(seed)) & 16'h3ffc), "data lanes");
        lane_sweep(1'b1, 16'h8000 | (16'($random(seed)) & 16'h3ffc), "reg lanes");
        lane_sweep(1'b0, 16'hc000 | (16'($random(seed)) & 16'h3ffc), "reg alias lanes");

        // Decode with random addresses, upper register bits included
        for (int i = 0; i < 24; i++) begin
            a = 16'($random(seed)) & 16'hfffc;
            access(i[0], a, 1'b1, SIZE_WORD, $random(seed), unused);
            check_read(~i[0], a, "decode");
        end

        contend(2'b00, 6, "inst contention");
        contend(2'b01, 6, "data contention");
        contend(2'b10, 4, "reg contention");

        // Both masters in flight on different targets
        for (int i = 0; i < 4; i++) begin
            fork
                check_read(1'b0, 16'(i * 4), "parallel imem");
                check_read(1'b1, 16'h4000 | 16'(i * 4), "parallel dmem");
            join
        end

        repeat (4) @(posedge clk);
        if (uut.u_assert.error_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("SIMULATION FAILED");
            $fatal(1, "assertions failed during the run");
        end
    end

endmodule

// File: build.f
logic/router_pkg.sv
logic/router_decode.sv
logic/router_arbiter.sv
logic/router_response.sv
logic/bus_router.sv
verification/bus_router_assert.sv
verification/bus_router_tb.sv

// File: Makefile
# Verilator flow for the bus router

TOP      ?= bus_router_tb
SEED     ?= 92
VFLAGS   ?= --timing --assert
OBJ_DIR  ?= obj_dir
FILELIST ?= build.f
ERRLIMIT ?= 100

VERILATOR ?= verilator

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -GSEED=$(SEED) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERRLIMIT)

clean:
	rm -rf $(OBJ_DIR)
